/* hdl/risacPkg.sv */
package risacPkg;

  // ==========================================================
  // basic word and register index types
  // ==========================================================

  // 32-bit data and byte address word
  typedef logic [31:0] wordT;

  // architectural register index
  typedef logic [4:0] regAddrT;

  // instruction class as seen by the back end
  // opNone marks anything outside the supported subset
  typedef enum logic [2:0] {
    opReg, opImm, opLui, opAuipc, opLoad, opStore, opNone
  } opClassT;

  // alu operation, funct3 plus bit 30 already resolved
  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu,
    aluXor, aluSrl, aluSra, aluOr, aluAnd
  } aluOpT;

  // ==========================================================
  // pipeline constants
  // ==========================================================

  // number of architectural registers, x0 included
  localparam int regCount = 32;

  // byte increment between consecutive instructions
  localparam wordT pcStep = 32'd4;

  // rv32i major opcodes of the supported subset
  localparam logic [6:0] opcodeReg   = 7'b0110011;
  localparam logic [6:0] opcodeImm   = 7'b0010011;
  localparam logic [6:0] opcodeLui   = 7'b0110111;
  localparam logic [6:0] opcodeAuipc = 7'b0010111;
  localparam logic [6:0] opcodeLoad  = 7'b0000011;
  localparam logic [6:0] opcodeStore = 7'b0100011;

endpackage

/* hdl/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage #(
  parameter risacPkg::wordT resetVector = 32'h0
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           ibusWait,
  input  logic           stall,
  output risacPkg::wordT pc,
  output logic           fetchRead
);
  import risacPkg::*;

  // an instruction is taken by the bus on read with no wait
  logic accept;

  assign accept = fetchRead && !ibusWait;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= resetVector;
      fetchRead <= 1'b1;
    end else begin
      // advance only when decode actually takes the word
      // a word returned during a stall is dropped and fetched again
      if (accept && !stall) begin
        pc <= pc + pcStep;
      end
      // read drops for one cycle after a stall
      // but a pending request under wait stays asserted
      fetchRead <= !stall || ibusWait;
    end
  end

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall,
  input  logic               instrValid,
  input  risacPkg::wordT     instr,
  input  risacPkg::wordT     instrAddr,
  output logic               valid,
  output risacPkg::opClassT  opClass,
  output risacPkg::aluOpT    aluOp,
  output risacPkg::regAddrT  rs1,
  output risacPkg::regAddrT  rs2,
  output risacPkg::regAddrT  rd,
  output logic               rdWe,
  output risacPkg::wordT     imm,
  output risacPkg::wordT     pcDec
);
  import risacPkg::*;

  opClassT classNext;
  aluOpT   aluNext;
  wordT    immNext;
  logic    rdWeNext;

  // ==========================================================
  // combinational decode of the incoming word
  // ==========================================================

  // classify on the full 7-bit opcode
  always_comb begin
    case (instr[6:0])
      opcodeReg:   classNext = opReg;
      opcodeImm:   classNext = opImm;
      opcodeLui:   classNext = opLui;
      opcodeAuipc: classNext = opAuipc;
      opcodeLoad:  classNext = opLoad;
      opcodeStore: classNext = opStore;
      default:     classNext = opNone;
    endcase
  end

  // immediate formats: I for alu-imm and loads, S for stores, U for lui/auipc
  always_comb begin
    case (classNext)
      opImm, opLoad:  immNext = {{20{instr[31]}}, instr[31:20]};
      opStore:        immNext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      opLui, opAuipc: immNext = {instr[31:12], 12'b0};
      default:        immNext = '0;
    endcase
  end

  // funct3 and bit 30 onto the alu op
  // loads, stores, lui and auipc all use add
  always_comb begin
    aluNext = aluAdd;
    if (classNext == opReg || classNext == opImm) begin
      case (instr[14:12])
        // no subi, bit 30 belongs to the immediate there
        3'b000: aluNext = (classNext == opReg && instr[30]) ? aluSub : aluAdd;
        3'b001: aluNext = aluSll;
        3'b010: aluNext = aluSlt;
        3'b011: aluNext = aluSltu;
        3'b100: aluNext = aluXor;
        // srai keeps bit 30 set like sra
        3'b101: aluNext = instr[30] ? aluSra : aluSrl;
        3'b110: aluNext = aluOr;
        3'b111: aluNext = aluAnd;
      endcase
    end
  end

  // every kept class except store writes rd
  assign rdWeNext = (classNext != opStore) && (classNext != opNone);

  // ==========================================================
  // decode register
  // ==========================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid   <= 1'b0;
      opClass <= opNone;
    end else if (!stall) begin
      // unsupported opcodes leave as a bubble
      valid   <= instrValid && (classNext != opNone);
      opClass <= classNext;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      aluOp <= aluNext;
      rs1   <= instr[19:15];
      rs2   <= instr[24:20];
      rd    <= instr[11:7];
      rdWe  <= rdWeNext;
      imm   <= immNext;
      pcDec <= instrAddr;
    end
  end

endmodule

/* hdl/operandStage.sv */
`timescale 1ns/1ps

module operandStage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               memStall,
  input  logic               decValid,
  input  risacPkg::opClassT  decOpClass,
  input  risacPkg::aluOpT    decAluOp,
  input  risacPkg::regAddrT  decRs1,
  input  risacPkg::regAddrT  decRs2,
  input  risacPkg::regAddrT  decRd,
  input  logic               decRdWe,
  input  risacPkg::wordT     decImm,
  input  risacPkg::wordT     decPc,
  input  risacPkg::wordT     rs1Data,
  input  risacPkg::wordT     rs2Data,
  input  logic               wbValid,
  input  risacPkg::regAddrT  wbRd,
  output logic               hazardStall,
  output logic               valid,
  output risacPkg::opClassT  opClass,
  output risacPkg::aluOpT    aluOp,
  output risacPkg::wordT     aluIn1,
  output risacPkg::wordT     aluIn2,
  output risacPkg::wordT     memAddr,
  output risacPkg::wordT     storeData,
  output risacPkg::regAddrT  rd,
  output logic               rdWe
);
  import risacPkg::*;

  // one pending bit per register, x0 stays clear
  logic [regCount-1:0] busy;
  logic [regCount-1:0] busyNext;
  logic                uses1;
  logic                uses2;
  logic                issue;
  wordT                in1Next;
  wordT                in2Next;

  // ==========================================================
  // hazard detection
  // ==========================================================

  // lui and auipc read no register, imm forms and loads read rs1 only
  assign uses1 = (decOpClass == opReg) || (decOpClass == opImm) ||
                 (decOpClass == opLoad) || (decOpClass == opStore);
  assign uses2 = (decOpClass == opReg) || (decOpClass == opStore);

  // a pending destination also stalls
  // otherwise an older write-back would clear the bit of a newer writer
  assign hazardStall = decValid && ((uses1 && busy[decRs1]) ||
                                    (uses2 && busy[decRs2]) ||
                                    (decRdWe && busy[decRd]));

  assign issue = decValid && !hazardStall;

  // clear on write-back first, so a same-cycle set wins
  always_comb begin
    busyNext = busy;
    if (wbValid) begin
      busyNext[wbRd] = 1'b0;
    end
    if (issue && decRdWe) begin
      busyNext[decRd] = 1'b1;
    end
    busyNext[0] = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else if (!memStall) begin
      busy <= busyNext;
    end
  end

  // ==========================================================
  // operand selection
  // ==========================================================

  // auipc adds to its own pc, lui adds to zero
  always_comb begin
    case (decOpClass)
      opAuipc: in1Next = decPc;
      opLui:   in1Next = '0;
      default: in1Next = rs1Data;
    endcase
  end

  assign in2Next = (decOpClass == opReg) ? rs2Data : decImm;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid   <= 1'b0;
      opClass <= opNone;
    end else if (!memStall) begin
      // bubble forward while the hazard holds decode
      valid   <= issue;
      opClass <= decOpClass;
    end
  end

  always_ff @(posedge clk) begin
    if (!memStall) begin
      aluOp     <= decAluOp;
      aluIn1    <= in1Next;
      aluIn2    <= in2Next;
      // load/store address, held on the bus under memStall
      memAddr   <= rs1Data + decImm;
      storeData <= rs2Data;
      rd        <= decRd;
      rdWe      <= decRdWe;
    end
  end

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               valid,
  input  risacPkg::opClassT  opClass,
  input  risacPkg::aluOpT    aluOp,
  input  risacPkg::wordT     aluIn1,
  input  risacPkg::wordT     aluIn2,
  input  risacPkg::regAddrT  rd,
  input  logic               rdWe,
  input  logic               dbusWait,
  input  risacPkg::wordT     dbusRdData,
  output logic               memStall,
  output logic               dbusRead,
  output logic               dbusWe,
  output logic               wbValid,
  output risacPkg::regAddrT  wbRd,
  output risacPkg::wordT     wbData
);
  import risacPkg::*;

  wordT aluResult;
  logic isLoad;
  logic isStore;

  // ==========================================================
  // data bus control
  // ==========================================================

  assign isLoad  = (opClass == opLoad);
  assign isStore = (opClass == opStore);

  // strobes straight from the operand register
  // address and store data come from operandStage
  assign dbusRead = valid && isLoad;
  assign dbusWe   = valid && isStore;

  // whole pipeline freezes until the transfer completes
  assign memStall = (dbusRead || dbusWe) && dbusWait;

  // ==========================================================
  // alu
  // ==========================================================

  always_comb begin
    case (aluOp)
      aluAdd:  aluResult = aluIn1 + aluIn2;
      aluSub:  aluResult = aluIn1 - aluIn2;
      // shift amount is the low five bits only
      aluSll:  aluResult = aluIn1 << aluIn2[4:0];
      aluSlt:  aluResult = {31'b0, $signed(aluIn1) < $signed(aluIn2)};
      aluSltu: aluResult = {31'b0, aluIn1 < aluIn2};
      aluXor:  aluResult = aluIn1 ^ aluIn2;
      aluSrl:  aluResult = aluIn1 >> aluIn2[4:0];
      aluSra:  aluResult = wordT'($signed(aluIn1) >>> aluIn2[4:0]);
      aluOr:   aluResult = aluIn1 | aluIn2;
      aluAnd:  aluResult = aluIn1 & aluIn2;
      default: aluResult = '0;
    endcase
  end

  // ==========================================================
  // write-back register
  // ==========================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wbValid <= 1'b0;
    end else if (!memStall) begin
      // stores never reach the register file
      wbValid <= valid && rdWe && !isStore;
    end
  end

  always_ff @(posedge clk) begin
    if (!memStall) begin
      wbRd <= rd;
      // load data is valid in the completing cycle
      wbData <= isLoad ? dbusRdData : aluResult;
    end
  end

endmodule

/* hdl/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
  input  logic               clk,
  input  logic               hold,
  input  risacPkg::regAddrT  rs1,
  input  risacPkg::regAddrT  rs2,
  output risacPkg::wordT     rs1Data,
  output risacPkg::wordT     rs2Data,
  input  logic               we,
  input  risacPkg::regAddrT  wrAddr,
  input  risacPkg::wordT     wrData
);
  import risacPkg::*;

  wordT    regs [regCount];
  // read addresses, captured alongside the decode register
  regAddrT rs1Q;
  regAddrT rs2Q;

  always_ff @(posedge clk) begin
    if (!hold) begin
      rs1Q <= rs1;
      rs2Q <= rs2;
    end
  end

  // a held address sees a write that lands while decode waits
  assign rs1Data = (rs1Q == '0) ? '0 : regs[rs1Q];
  assign rs2Data = (rs2Q == '0) ? '0 : regs[rs2Q];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wrAddr] <= wrData;
    end
  end

endmodule

/* hdl/risacTop.sv */
`timescale 1ns/1ps

module risacTop #(
  parameter risacPkg::wordT resetVector = 32'h0
) (
  input  logic           clk,
  input  logic           rst_n,
  output risacPkg::wordT ibusAddr,
  output logic           ibusRead,
  input  risacPkg::wordT ibusData,
  input  risacPkg::wordT ibusDataAddr,
  input  logic           ibusWait,
  output risacPkg::wordT dbusAddr,
  output risacPkg::wordT dbusWrData,
  output logic           dbusRead,
  output logic           dbusWe,
  input  risacPkg::wordT dbusRdData,
  input  logic           dbusWait
);
  import risacPkg::*;

  // ==========================================================
  // stage-to-stage wires
  // ==========================================================

  logic    stall;
  logic    memStall;
  logic    hazardStall;
  logic    instrValid;

  // decode outputs
  logic    decValid;
  opClassT decOpClass;
  aluOpT   decAluOp;
  regAddrT decRs1;
  regAddrT decRs2;
  regAddrT decRd;
  logic    decRdWe;
  wordT    decImm;
  wordT    decPc;

  // register file read data
  wordT    rs1Data;
  wordT    rs2Data;

  // operand outputs
  logic    opValid;
  opClassT opOpClass;
  aluOpT   opAluOp;
  wordT    aluIn1;
  wordT    aluIn2;
  regAddrT opRd;
  logic    opRdWe;

  // write-back
  logic    wbValid;
  regAddrT wbRd;
  wordT    wbData;

  // fetch and decode wait on either stall source
  assign stall      = memStall || hazardStall;
  assign instrValid = ibusRead && !ibusWait;

  fetchStage #(
    .resetVector(resetVector)
  ) fetchStage_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .ibusWait (ibusWait),
    .stall    (stall),
    .pc       (ibusAddr),
    .fetchRead(ibusRead)
  );

  decodeStage decodeStage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .instrValid(instrValid),
    .instr     (ibusData),
    .instrAddr (ibusDataAddr),
    .valid     (decValid),
    .opClass   (decOpClass),
    .aluOp     (decAluOp),
    .rs1       (decRs1),
    .rs2       (decRs2),
    .rd        (decRd),
    .rdWe      (decRdWe),
    .imm       (decImm),
    .pcDec     (decPc)
  );

  // read addresses taken from the incoming word, in step with decode
  registerFile registerFile_inst (
    .clk    (clk),
    .hold   (stall),
    .rs1    (ibusData[19:15]),
    .rs2    (ibusData[24:20]),
    .rs1Data(rs1Data),
    .rs2Data(rs2Data),
    .we     (wbValid),
    .wrAddr (wbRd),
    .wrData (wbData)
  );

  operandStage operandStage_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .memStall   (memStall),
    .decValid   (decValid),
    .decOpClass (decOpClass),
    .decAluOp   (decAluOp),
    .decRs1     (decRs1),
    .decRs2     (decRs2),
    .decRd      (decRd),
    .decRdWe    (decRdWe),
    .decImm     (decImm),
    .decPc      (decPc),
    .rs1Data    (rs1Data),
    .rs2Data    (rs2Data),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .hazardStall(hazardStall),
    .valid      (opValid),
    .opClass    (opOpClass),
    .aluOp      (opAluOp),
    .aluIn1     (aluIn1),
    .aluIn2     (aluIn2),
    .memAddr    (dbusAddr),
    .storeData  (dbusWrData),
    .rd         (opRd),
    .rdWe       (opRdWe)
  );

  executeStage executeStage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (opValid),
    .opClass   (opOpClass),
    .aluOp     (opAluOp),
    .aluIn1    (aluIn1),
    .aluIn2    (aluIn2),
    .rd        (opRd),
    .rdWe      (opRdWe),
    .dbusWait  (dbusWait),
    .dbusRdData(dbusRdData),
    .memStall  (memStall),
    .dbusRead  (dbusRead),
    .dbusWe    (dbusWe),
    .wbValid   (wbValid),
    .wbRd      (wbRd),
    .wbData    (wbData)
  );

endmodule

/* sim/risacAssertions.sv */
`timescale 1ns/1ps

module risacAssertions (
  input logic           clk,
  input logic           rst_n,
  input risacPkg::wordT ibusAddr,
  input risacPkg::wordT dbusAddr,
  input logic           dbusRead,
  input logic           dbusWe
  ,
  input logic           dbusWait
);
  import risacPkg::*;

  // ==========================================================
  // data bus
  // ==========================================================

  // a transfer is a read or a write, never both
  noReadWrite: assert property (@(posedge clk) disable iff (!rst_n)
      !(dbusRead && dbusWe))
    else $error("dbusRead and dbusWe asserted together");

  // a waiting request keeps its address and direction
  dbusHeld: assert property (@(posedge clk) disable iff (!rst_n)
      (dbusRead || dbusWe) && dbusWait |=> $stable(dbusAddr) && $stable(dbusWe))
    else $error("dbus request changed while dbusWait was high");

  // ==========================================================
  // instruction bus
  // ==========================================================

  // no branches, so the fetch address only steps forward
  ibusStep: assert property (@(posedge clk) disable iff (!rst_n)
      $changed(ibusAddr) |-> ibusAddr == $past(ibusAddr) + pcStep)
    else $error("ibusAddr moved by something other than one instruction");

endmodule

/* sim/risacTb.sv */
`timescale 1ns/1ps

module risacTb;
  import risacPkg::*;

  localparam wordT resetVector = 32'h0;
  localparam int   resetCycles = 4;
  localparam int   progMax     = 128;
  localparam int   dataWords   = 64;
  localparam int   storeMax    = 48;

  // section offsets inside the pattern image
  localparam int   countBase   = 'h00;
  localparam int   dataBase    = 'h10;
  localparam int   storeBase   = 'h20;
  localparam int   progBase    = 'h80;

  logic clk;
  logic rst_n;
  wordT ibusAddr;
  logic ibusRead;
  wordT ibusData;
  wordT ibusDataAddr;
  logic ibusWait;
  wordT dbusAddr;
  wordT dbusWrData;
  logic dbusRead;
  logic dbusWe;
  wordT dbusRdData;
  logic dbusWait;

  // pattern image and the three arrays split out of it
  wordT patMem [256];
  wordT progMem [progMax];
  wordT dmem [dataWords];
  wordT expAddr [storeMax];
  wordT expData [storeMax];
  wordT progLen;
  wordT dataLen;
  wordT storeLen;

  int   storeIdx;
  int   mismatchCount;
  int   otherCount;
  int   cycleCount;
  int   cycleLimit;
  int   waitLeft;
  logic heldValid;
  wordT heldAddr;
  wordT heldData;
  wordT fetchIndex;

  risacTop #(
    .resetVector(resetVector)
  ) risacTop_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .ibusAddr    (ibusAddr),
    .ibusRead    (ibusRead),
    .ibusData    (ibusData),
    .ibusDataAddr(ibusDataAddr),
    .ibusWait    (ibusWait),
    .dbusAddr    (dbusAddr),
    .dbusWrData  (dbusWrData),
    .dbusRead    (dbusRead),
    .dbusWe      (dbusWe),
    .dbusRdData  (dbusRdData),
    .dbusWait    (dbusWait)
  );

  bind risacTop risacAssertions risacAssertions_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ibusAddr(ibusAddr),
    .dbusAddr(dbusAddr),
    .dbusRead(dbusRead),
    .dbusWe  (dbusWe),
    .dbusWait(dbusWait)
  );

  always #5 clk = ~clk;

  // ==========================================================
  // compare tasks
  // ==========================================================

  task automatic checkWord(input string testName, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %08h, actual %08h", testName, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic checkAddr(input string testName, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("ERR %s: expected address %08h, actual %08h", testName, expected, actual);
      mismatchCount++;
    end
  endtask

  task automatic checkBit(input string testName, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %s: expected %b, actual %b", testName, expected, actual);
      mismatchCount++;
    end
  endtask

  // ==========================================================
  // pattern loading
  // ==========================================================

  task automatic loadPatterns();
    $readmemh("sim/risacPatterns.txt", patMem);
    progLen  = patMem[countBase];
    dataLen  = patMem[countBase + 1];
    storeLen = patMem[countBase + 2];
    if (progLen > progMax || dataLen > 16 || storeLen > storeMax) begin
      $display("pattern file section counts are out of range");
      otherCount++;
    end
    for (int i = 0; i < progMax; i++) begin
      progMem[i] = patMem[progBase + i];
    end
    // unwritten words still differ from address to address
    for (int i = 0; i < dataWords; i++) begin
      dmem[i] = 32'hA5000000 ^ (i * pcStep);
    end
    for (int i = 0; i < int'(dataLen); i++) begin
      dmem[i] = patMem[dataBase + i];
    end
    for (int i = 0; i < storeMax; i++) begin
      expAddr[i] = patMem[storeBase + 2 * i];
      expData[i] = patMem[storeBase + 2 * i + 1];
    end
  endtask

  // compare one completed store with the next expected pair
  task automatic recordStore(input wordT addr, input wordT data);
    string name;
    if (storeIdx >= int'(storeLen)) begin
      $display("unexpected extra store to %08h with data %08h", addr, data);
      otherCount++;
    end else begin
      name = $sformatf("store %0d", storeIdx);
      checkAddr(name, expAddr[storeIdx], addr);
      checkWord(name, expData[storeIdx], data);
    end
    dmem[addr[7:2]] <= data;
    storeIdx++;
  endtask

  // ==========================================================
  // memory models
  // ==========================================================

  // instruction memory answers in the same cycle and never waits
  // past the program end it returns zero, which decodes as a bubble
  always_comb begin
    fetchIndex = (ibusAddr - resetVector) / pcStep;
    ibusData   = (fetchIndex < progLen) ? progMem[fetchIndex[6:0]] : '0;
  end

  assign ibusDataAddr = ibusAddr;

  // read data is combinational so it is valid in the completing cycle
  assign dbusRdData = dmem[dbusAddr[7:2]];

  // wait length for the next transfer is drawn when the previous one completes
  always @(posedge clk) begin : dbusModel
    int unsigned draw;
    if (rst_n && (dbusRead || dbusWe)) begin
      if (dbusRead && dbusWe) begin
        $display("dbusRead and dbusWe were high in the same cycle");
        otherCount++;
      end
      // request must not move while it waits
      if (heldValid) begin
        checkAddr("dbus address held", heldAddr, dbusAddr);
        if (dbusWe) begin
          checkWord("dbus store data held", heldData, dbusWrData);
        end
      end
      if (dbusWait) begin
        heldValid <= 1'b1;
        heldAddr  <= dbusAddr;
        heldData  <= dbusWrData;
        waitLeft  <= waitLeft - 1;
        dbusWait  <= (waitLeft > 1);
      end else begin
        heldValid <= 1'b0;
        if (dbusWe) begin
          recordStore(dbusAddr, dbusWrData);
        end
        draw     = $urandom % 4;
        waitLeft <= int'(draw);
        dbusWait <= (draw != 0);
      end
    end
  end

  // ==========================================================
  // main sequence
  // ==========================================================

  initial begin
    void'($urandom(32'h7a0e6ee2));
    clk           = 1'b0;
    rst_n         = 1'b0;
    ibusWait      = 1'b0;
    dbusWait      = 1'b0;
    waitLeft      = 0;
    heldValid     = 1'b0;
    heldAddr      = '0;
    heldData      = '0;
    storeIdx      = 0;
    mismatchCount = 0;
    otherCount    = 0;
    cycleCount    = 0;
    loadPatterns();
    cycleLimit = 20 * int'(progLen) + 200;

    repeat (resetCycles) @(posedge clk);
    rst_n <= 1'b1;

    // first cycle out of reset
    @(negedge clk);
    checkBit("reset dbusRead", 1'b0, dbusRead);
    checkBit("reset dbusWe", 1'b0, dbusWe);
    checkBit("reset ibusRead", 1'b1, ibusRead);
    checkAddr("reset ibusAddr", resetVector, ibusAddr);

    while (storeIdx < int'(storeLen) && cycleCount < cycleLimit) begin
      @(negedge clk);
      cycleCount++;
    end

    if (storeIdx < int'(storeLen)) begin
      $display("timeout after %0d cycles, %0d of %0d stores seen",
               cycleCount, storeIdx, storeLen);
      otherCount++;
    end else begin
      // let the pipeline drain so a stray store is still caught
      repeat (20) @(negedge clk);
    end

    $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* sim/risacPatterns.txt */
// counts at @00: program words, data words, store pairs
// data words at @10, store pairs (address data) at @20, program at @80
@00
0000002B 00000003 00000012
@10
F0000005 00000003 00000010
@20
00000040 F0000008
00000044 F0000002
00000048 80000028
0000004C 00000001
00000050 00000000
00000054 F0000006
00000058 1E000000
0000005C FE000000
00000060 F0000007
00000064 00000001
00000068 FFFFFFFC
0000006C 00000050
00000070 0000000F
00000074 FFFFFFFF
00000078 ABCDE000
0000007C 00001080
00000080 00000015
00000084 1000012A
@80
00002083 // lw   x1, 0(x0)
00402103 // lw   x2, 4(x0)
002081B3 // add  x3, x1, x2
04302023 // sw   x3, 0x40(x0)
402081B3 // sub  x3, x1, x2
04302223 // sw   x3, 0x44(x0)
002091B3 // sll  x3, x1, x2
04302423 // sw   x3, 0x48(x0)
0020A1B3 // slt  x3, x1, x2
04302623 // sw   x3, 0x4c(x0)
0020B1B3 // sltu x3, x1, x2
04302823 // sw   x3, 0x50(x0)
0020C1B3 // xor  x3, x1, x2
04302A23 // sw   x3, 0x54(x0)
0020D1B3 // srl  x3, x1, x2
04302C23 // sw   x3, 0x58(x0)
4020D1B3 // sra  x3, x1, x2
04302E23 // sw   x3, 0x5c(x0)
0020E1B3 // or   x3, x1, x2
06302023 // sw   x3, 0x60(x0)
0020F1B3 // and  x3, x1, x2
06302223 // sw   x3, 0x64(x0)
FF910213 // addi x4, x2, -7
06402423 // sw   x4, 0x68(x0)
00409293 // slli x5, x1, 4
06502623 // sw   x5, 0x6c(x0)
01C0D313 // srli x6, x1, 28
06602823 // sw   x6, 0x70(x0)
41C0D393 // srai x7, x1, 28
06702A23 // sw   x7, 0x74(x0)
ABCDE437 // lui  x8, 0xabcde
06802C23 // sw   x8, 0x78(x0)
00001497 // auipc x9, 0x1 at 0x80
06902E23 // sw   x9, 0x7c(x0)
00802503 // lw   x10, 8(x0)
00550593 // addi x11, x10, 5 (load-use)
08B02023 // sw   x11, 0x80(x0)
00158613 // addi x12, x11, 1
00161693 // slli x13, x12, 1
0026C733 // xor  x14, x13, x2
401707B3 // sub  x15, x14, x1
1007E813 // ori  x16, x15, 0x100
09002223 // sw   x16, 0x84(x0)

/* risacTop.f */
hdl/risacPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/operandStage.sv
hdl/executeStage.sv
hdl/registerFile.sv
hdl/risacTop.sv
sim/risacAssertions.sv
sim/risacTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the risacTop testbench with verilator
# the exit status follows the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module risacTb -f risacTop.f -o risacSim \
  && ./obj_dir/risacSim | tee /dev/stderr | grep -qx "sim passed" \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
